/* battleshipPico.f */
logic/battleshipPicoPkg.sv
logic/occupancyAccumulator.sv
logic/boardRamSteer.sv
logic/gameDisplayRegs.sv
logic/xbeeLink.sv
logic/picoHostPort.sv
logic/battleshipPicoIf.sv
tests/battleshipPicoIf_chk.sv
tests/battleshipPicoTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = battleshipPicoTb
FILELIST  = battleshipPico.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+100

SOURCES = $(shell grep -v '^+' $(FILELIST))
SIM     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tests/battleshipPicoTb.sv */
////////////////////
// battleship pico testbench
// drives the port bus, board cells and link pins of the interface
////////////////////
`default_nettype none

module battleshipPicoTb;
  import battleshipPicoPkg::*;

  localparam portAddr_t idleAddr     = 8'hFE; // unmapped, reads zero
  localparam int        waitLimit    = 50;    // cycles before a wait gives up
  localparam int        selInterrupt = 0;
  localparam int        selTxSend    = 1;

  logic           clk;
  logic           reset;
  portAddr_t      portId;
  byte_t          outPort;
  logic           writeStrobe;
  byte_t          inPort;
  logic           intRequest;
  logic           interruptAck;
  logic           interrupt;
  logic           connEstablished;
  logic [4:0]     buttons;
  byte_t          switches;
  byte_t          cursor;
  boardRam_t      usRamPort;
  boardRam_t      themRamPort;
  cellValue_t     usReadValue;
  cellValue_t     themReadValue;
  placementInfo_t placement;
  displayRegs_t   display;
  logic           rxReady;
  byte_t          rxData;
  logic           txSend;
  byte_t          txData;

  int errors      = 0;
  int testErrors  = 0; // error count when the current test began
  int testsRun    = 0;
  int testsFailed = 0;

  battleshipPicoIf battleshipPicoIf_i (
    .clk, .reset, .portId, .outPort, .writeStrobe, .inPort, .intRequest,
    .interruptAck, .interrupt, .connEstablished, .buttons, .switches, .cursor,
    .usRamPort, .themRamPort, .usReadValue, .themReadValue, .placement,
    .display, .rxReady, .rxData, .txSend, .txData
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // checks and bus tasks
  task automatic checkByte(input string name, input byte_t got, input byte_t expected);
    assert (got == expected) else begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  task automatic endTest(input string name);
    int newErrors;
    newErrors = errors - testErrors;
    testsRun++;
    if (newErrors == 0) begin
      $display("test %s: passed", name);
    end else begin
      testsFailed++;
      $display("test %s: failed with %0d errors", name, newErrors);
    end
    testErrors = errors;
  endtask

  task automatic writePort(input portAddr_t addr, input byte_t data);
    @(posedge clk);
    portId      <= addr;
    outPort     <= data;
    writeStrobe <= 1'b1;
    @(posedge clk);        // register loads here
    portId      <= idleAddr;
    writeStrobe <= 1'b0;
    @(negedge clk);        // new value is stable
  endtask

  task automatic readPort(input portAddr_t addr, output byte_t data);
    @(posedge clk);
    portId <= addr;
    @(posedge clk);        // inPort captures the addressed value
    portId <= idleAddr;
    @(negedge clk);
    data = inPort;
  endtask

  task automatic pulseRx(input byte_t data);
    @(posedge clk);
    rxReady <= 1'b1;
    rxData  <= data;
    @(posedge clk);
    rxReady <= 1'b0;
  endtask

  function automatic logic levelOf(input int sel);
    return (sel == selInterrupt) ? interrupt : txSend;
  endfunction

  task automatic waitLevel(input int sel, input logic level, input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (levelOf(sel) !== level && cycles < waitLimit) begin
      @(negedge clk);
      cycles++;
    end
    assert (levelOf(sel) === level) else begin
      errors++;
      $display("timeout waiting for %s to go %s", name, level ? "high" : "low");
    end
  endtask

  ////////////////////
  // tests
  task automatic testWriteRegs();
    byte_t data;
    byte_t readBack;
    data = 8'($urandom);
    writePort(paLeds, data);
    checkByte("display.leds", display.leds, data);
    data = 8'($urandom);
    writePort(paDig0, data);
    checkByte("display.dig0", 8'(display.dig0), {3'b000, data[4:0]}); // 5-bit digit
    data = 8'($urandom);
    writePort(paDig1, data);
    checkByte("display.dig1", 8'(display.dig1), {3'b000, data[4:0]});
    data = 8'($urandom);
    writePort(paDig2, data);
    checkByte("display.dig2", 8'(display.dig2), {3'b000, data[4:0]});
    data = 8'($urandom);
    writePort(paDig3, data);
    checkByte("display.dig3", 8'(display.dig3), {3'b000, data[4:0]});
    data = 8'($urandom);
    writePort(paDecimalPoints, data);
    checkByte("display.decimalPoints", 8'(display.decimalPoints), {4'h0, data[3:0]});
    data = 8'($urandom);
    writePort(paOrientation, data);
    checkByte("placement.orientation", 8'(placement.orientation), {4'h0, data[3:0]});
    data = 8'($urandom);
    writePort(paShipInfo, data);
    checkByte("placement.shipInfo", placement.shipInfo, data);
    data = 8'($urandom);
    writePort(paPlaceDone, data);
    checkByte("placement.placementDone", 8'(placement.placementDone), {6'b0, data[1:0]});
    @(posedge clk);
    buttons  <= 5'($urandom);
    switches <= 8'($urandom);
    readPort(paButtons, readBack);
    checkByte("inPort", readBack, {3'b000, buttons}); // zero-extended buttons
    readPort(paSwitches, readBack);
    checkByte("inPort", readBack, switches);
  endtask

  task automatic testRamSteer();
    byte_t addr;
    byte_t value;
    byte_t readBack;
    writePort(paRamSelect, {7'b0, usRam});
    addr = 8'($urandom);
    writePort(paCursorCheck, addr);
    checkByte("cursor", cursor, addr);
    checkByte("usRamPort.readAddr", usRamPort.readAddr, addr);
    addr = 8'($urandom);
    writePort(paRamWriteAddr, addr);
    checkByte("usRamPort.writeAddr", usRamPort.writeAddr, addr);
    checkByte("usRamPort.writeEnable", 8'(usRamPort.writeEnable), 8'h01);
    checkByte("themRamPort.writeEnable", 8'(themRamPort.writeEnable), 8'h00);
    writePort(paRamSelect, {7'b0, themRam});
    addr = 8'($urandom);
    writePort(paCursorCheck, addr);               // also stops the us write
    checkByte("cursor", cursor, addr);
    checkByte("themRamPort.readAddr", themRamPort.readAddr, addr);
    checkByte("usRamPort.writeEnable", 8'(usRamPort.writeEnable), 8'h00);
    addr = 8'($urandom);
    writePort(paRamWriteAddr, addr);
    checkByte("themRamPort.writeAddr", themRamPort.writeAddr, addr);
    checkByte("themRamPort.writeEnable", 8'(themRamPort.writeEnable), 8'h01);
    checkByte("usRamPort.writeEnable", 8'(usRamPort.writeEnable), 8'h00);
    value = 8'($urandom);
    writePort(paRamWriteValue, value);
    checkByte("themRamPort.writeValue", 8'(themRamPort.writeValue), {6'b0, value[1:0]});
    @(posedge clk);
    usReadValue   <= 2'b01;
    themReadValue <= 2'b10;
    readPort(paDataRam, readBack);
    checkByte("inPort", readBack, 8'h02);         // them cell
    writePort(paRamSelect, {7'b0, usRam});
    readPort(paDataRam, readBack);
    checkByte("inPort", readBack, 8'h01);         // us cell
    value = 8'($urandom);
    writePort(paRamWriteValue, value);
    checkByte("usRamPort.writeValue", 8'(usRamPort.writeValue), {6'b0, value[1:0]});
    addr = 8'($urandom);
    writePort(paRamWriteAddr, addr);
    checkByte("usRamPort.writeEnable", 8'(usRamPort.writeEnable), 8'h01);
    addr = 8'($urandom);
    writePort(paShipCheck3, addr);                // ship probe ends the us write
    checkByte("cursor", cursor, addr);
    checkByte("usRamPort.writeEnable", 8'(usRamPort.writeEnable), 8'h00);
    @(posedge clk);
    usReadValue   <= '0;
    themReadValue <= '0;
  endtask

  task automatic testPlacementValid();
    byte_t readBack;
    readPort(paValidFlag, readBack);              // flushes cells summed earlier
    repeat (2) @(posedge clk);
    readPort(paValidFlag, readBack);
    checkByte("inPort (valid flag)", readBack, validFlag);
    @(posedge clk);
    usReadValue <= 2'b01;
    repeat (256) @(posedge clk);                  // a wrapping 8-bit sum would be zero
    usReadValue <= '0;
    readPort(paValidFlag, readBack);
    checkByte("inPort (valid flag)", readBack, invalidFlag);
    repeat (2) @(posedge clk);
    readPort(paValidFlag, readBack);
    checkByte("inPort (valid flag)", readBack, validFlag);
    writePort(paOutOfBounds, outOfBoundsMark);
    readPort(paValidFlag, readBack);
    repeat (2) @(posedge clk);
    readPort(paValidFlag, readBack);              // empty sum, cursor off board
    checkByte("inPort (valid flag)", readBack, invalidFlag);
    writePort(paOutOfBounds, 8'h00);
    readPort(paValidFlag, readBack);
    checkByte("inPort (valid flag)", readBack, validFlag);
  endtask

  task automatic testReceive();
    byte_t data;
    byte_t readBack;
    @(posedge clk);
    connEstablished <= 1'b1;
    data = 8'($urandom);
    pulseRx(data);
    readPort(paLinkStatus, readBack);
    checkByte("inPort (link status)", readBack, {1'b1, 1'b1, 6'b0});
    readPort(paDataRx, readBack);
    checkByte("inPort (rx data)", readBack, data);
    readPort(paLinkStatus, readBack);             // read dropped the pending bit
    checkByte("inPort (link status)", readBack, {1'b1, 1'b0, 6'b0});
    @(posedge clk);
    connEstablished <= 1'b0;
    readPort(paLinkStatus, readBack);
    checkByte("inPort (link status)", readBack, 8'h00);
  endtask

  task automatic testTransmit();
    byte_t data;
    byte_t readBack;
    data = 8'($urandom);
    writePort(paDataTx, data);
    waitLevel(selTxSend, 1'b1, "txSend");
    checkByte("txData", txData, data);
    repeat (5) @(posedge clk);
    @(negedge clk);
    checkByte("txSend", 8'(txSend), 8'h01);       // level holds with no reply
    pulseRx(8'($urandom));
    waitLevel(selTxSend, 1'b0, "txSend");
    readPort(paDataRx, readBack);                 // consume the reply byte
  endtask

  task automatic testInterrupt();
    @(posedge clk);
    intRequest <= 1'b1;
    @(posedge clk);
    intRequest <= 1'b0;
    waitLevel(selInterrupt, 1'b1, "interrupt");
    repeat (4) @(posedge clk);
    @(negedge clk);
    checkByte("interrupt", 8'(interrupt), 8'h01);
    @(posedge clk);
    interruptAck <= 1'b1;
    @(posedge clk);
    interruptAck <= 1'b0;
    waitLevel(selInterrupt, 1'b0, "interrupt");
    @(posedge clk);
    intRequest   <= 1'b1;                         // request and ack together
    interruptAck <= 1'b1;
    @(posedge clk);
    intRequest   <= 1'b0;
    interruptAck <= 1'b0;
    @(negedge clk);
    checkByte("interrupt", 8'(interrupt), 8'h00);
    @(negedge clk);
    checkByte("interrupt", 8'(interrupt), 8'h00);
  endtask

  ////////////////////
  // main sequence
  initial begin
    void'($urandom(32'h342c));
    reset           = 1'b1;
    portId          = idleAddr;
    outPort         = '0;
    writeStrobe     = 1'b0;
    intRequest      = 1'b0;
    interruptAck    = 1'b0;
    connEstablished = 1'b0;
    buttons         = '0;
    switches        = '0;
    usReadValue     = '0;
    themReadValue   = '0;
    rxReady         = 1'b0;
    rxData          = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    testWriteRegs();
    endTest("write registers");
    testRamSteer();
    endTest("ram steering");
    testPlacementValid();
    endTest("placement validity");
    testReceive();
    endTest("receive");
    testTransmit();
    endTest("transmit");
    testInterrupt();
    endTest("interrupt");

    $display("%0d tests run, %0d failed, %0d check errors, bound assertions %s",
             testsRun, testsFailed, errors,
             battleshipPicoIf_i.chk.anyFail ? "failing" : "clean");
    if (errors == 0 && !battleshipPicoIf_i.chk.anyFail) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/battleshipPicoIf_chk.sv */
////////////////////
// battleship pico checker
// one-cycle rules for interrupt, send level, rx pending and
// write enables coming out of reset
////////////////////
`default_nettype none

module battleshipPicoChk (
  input logic                         clk,
  input logic                         reset,
  input battleshipPicoPkg::portAddr_t portId,
  input logic                         writeStrobe,
  input logic                         rxReady,
  input logic                         intRequest,
  input logic                         interruptAck,
  input logic                         interrupt,
  input logic                         txSend,
  input logic                         rxPending,
  input battleshipPicoPkg::boardRam_t usRamPort,
  input battleshipPicoPkg::boardRam_t themRamPort
);
  import battleshipPicoPkg::*;

  logic txWrite;             // qualified write to the tx port
  logic failIntSet   = 1'b0; // one sticky flag per property
  logic failIntClear = 1'b0;
  logic failTxSet    = 1'b0;
  logic failTxClear  = 1'b0;
  logic failRxSet    = 1'b0;
  logic failRxClear  = 1'b0;
  logic failWeReset  = 1'b0;
  logic anyFail;

  assign txWrite = writeStrobe && (portId == paDataTx);
  assign anyFail = failIntSet | failIntClear | failTxSet | failTxClear |
                   failRxSet | failRxClear | failWeReset;

  ////////////////////
  // interrupt latch, ack has priority
  intSet: assert property (@(posedge clk) disable iff (reset)
    intRequest && !interruptAck |=> interrupt)
    else begin failIntSet = 1'b1; $error("interrupt did not rise after request"); end
  intClear: assert property (@(posedge clk) disable iff (reset)
    interruptAck |=> !interrupt)
    else begin failIntClear = 1'b1; $error("interrupt did not fall after ack"); end

  // send level, a write beats a receive
  txSet: assert property (@(posedge clk) disable iff (reset) txWrite |=> txSend)
    else begin failTxSet = 1'b1; $error("txSend not set by tx write"); end
  txClear: assert property (@(posedge clk) disable iff (reset)
    rxReady && !txWrite |=> !txSend)
    else begin failTxClear = 1'b1; $error("txSend not cleared by rxReady"); end

  ////////////////////
  // rx pending, a new byte beats the read
  rxSet: assert property (@(posedge clk) disable iff (reset) rxReady |=> rxPending)
    else begin failRxSet = 1'b1; $error("rxPending not set by rxReady"); end
  rxClear: assert property (@(posedge clk) disable iff (reset)
    !rxReady && portId == paDataRx |=> !rxPending)
    else begin failRxClear = 1'b1; $error("rxPending not cleared by rx read"); end

  weReset: assert property (@(posedge clk)
    reset |=> !usRamPort.writeEnable && !themRamPort.writeEnable)
    else begin failWeReset = 1'b1; $error("write enable high after reset"); end

endmodule

bind battleshipPicoIf battleshipPicoChk chk (
  .clk, .reset, .portId, .writeStrobe, .rxReady, .intRequest, .interruptAck,
  .interrupt, .txSend, .rxPending, .usRamPort, .themRamPort
);

`default_nettype wire

/* logic/battleshipPicoIf.sv */
////////////////////
// battleship pico interface
// connects the processor port bus to the game port blocks
////////////////////
`default_nettype none

module battleshipPicoIf (
  input  logic                              clk,
  input  logic                              reset,
  input  battleshipPicoPkg::portAddr_t      portId,
  input  battleshipPicoPkg::byte_t          outPort,
  input  logic                              writeStrobe,
  output battleshipPicoPkg::byte_t          inPort,
  input  logic                              intRequest,
  input  logic                              interruptAck,
  output logic                              interrupt,
  input  logic                              connEstablished,
  input  logic [4:0]                        buttons,
  input  battleshipPicoPkg::byte_t          switches,
  output battleshipPicoPkg::byte_t          cursor,
  output battleshipPicoPkg::boardRam_t      usRamPort,
  output battleshipPicoPkg::boardRam_t      themRamPort,
  input  battleshipPicoPkg::cellValue_t     usReadValue,
  input  battleshipPicoPkg::cellValue_t     themReadValue,
  output battleshipPicoPkg::placementInfo_t placement,
  output battleshipPicoPkg::displayRegs_t   display,
  input  logic                              rxReady,
  input  battleshipPicoPkg::byte_t          rxData,
  output logic                              txSend,
  output battleshipPicoPkg::byte_t          txData
);
  import battleshipPicoPkg::*;

  picoBus_t   bus;            // shared by every port block
  byte_t      outOfBounds;
  logic       placementValid;
  cellValue_t ramReadData;    // cell from the selected board
  byte_t      rxByte;
  logic       rxPending;

  assign bus = '{portId: portId, outPort: outPort, writeStrobe: writeStrobe};

  occupancyAccumulator occupancy (
    .clk, .reset, .bus, .usReadValue, .outOfBounds, .placementValid
  );

  boardRamSteer ramSteer (
    .clk, .reset, .bus, .usReadValue, .themReadValue,
    .usRamPort, .themRamPort, .cursor, .ramReadData
  );

  gameDisplayRegs displayRegs (
    .clk, .reset, .bus, .display, .placement, .outOfBounds
  );

  xbeeLink link (
    .clk, .reset, .bus, .rxReady, .rxData,
    .txSend, .txData, .rxByte, .rxPending
  );

  ////////////////////
  // processor read side and interrupt
  picoHostPort hostPort (
    .clk, .reset, .bus, .buttons, .switches, .connEstablished,
    .rxPending, .rxByte, .placementValid, .ramReadData,
    .intRequest, .interruptAck, .inPort, .interrupt
  );

endmodule

`default_nettype wire

/* logic/picoHostPort.sv */
////////////////////
// pico host port
// registered in-port mux and request/ack interrupt latch
////////////////////
`default_nettype none

module picoHostPort (
  input  logic                          clk,
  input  logic                          reset,
  input  battleshipPicoPkg::picoBus_t   bus,
  input  logic [4:0]                    buttons,
  input  battleshipPicoPkg::byte_t      switches,
  input  logic                          connEstablished,
  input  logic                          rxPending,
  input  battleshipPicoPkg::byte_t      rxByte,
  input  logic                          placementValid,
  input  battleshipPicoPkg::cellValue_t ramReadData,
  input  logic                          intRequest,
  input  logic                          interruptAck,
  output battleshipPicoPkg::byte_t      inPort,
  output logic                          interrupt
);
  import battleshipPicoPkg::*;

  ////////////////////
  // read side, no read strobe needed
  always_ff @(posedge clk) begin
    if (reset) begin
      inPort <= '0;
    end else begin
      case (bus.portId)
        paButtons:    inPort <= {3'b000, buttons};
        paSwitches:   inPort <= switches;                          // low byte only
        paLinkStatus: inPort <= {connEstablished, rxPending, 6'b0};
        paValidFlag:  inPort <= placementValid ? validFlag : invalidFlag;
        paDataRx:     inPort <= rxByte;
        paDataRam:    inPort <= {6'b0, ramReadData};               // selected board cell
        default:      inPort <= '0;
      endcase
    end
  end

  ////////////////////
  // interrupt stays up until the processor acks
  always_ff @(posedge clk) begin
    if (reset) begin
      interrupt <= 1'b0;
    end else if (interruptAck) begin
      interrupt <= 1'b0; // ack beats a new request
    end else if (intRequest) begin
      interrupt <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/xbeeLink.sv */
////////////////////
// XBee link
// holds received byte until read, transmit byte and send level
////////////////////
`default_nettype none

module xbeeLink (
  input  logic                        clk,
  input  logic                        reset,
  input  battleshipPicoPkg::picoBus_t bus,
  input  logic                        rxReady,
  input  battleshipPicoPkg::byte_t    rxData,
  output logic                        txSend,
  output battleshipPicoPkg::byte_t    txData,
  output battleshipPicoPkg::byte_t    rxByte,
  output logic                        rxPending
);
  import battleshipPicoPkg::*;

  logic txWrite;

  assign txWrite = bus.writeStrobe && (bus.portId == paDataTx);

  always_ff @(posedge clk) begin
    if (reset) begin
      rxByte    <= '0;
      rxPending <= 1'b0;
      txData    <= '0;
      txSend    <= 1'b0;
    end else begin
      if (rxReady) rxByte <= rxData; // newest byte wins, no back-pressure

      if (rxReady) rxPending <= 1'b1;
      else if (bus.portId == paDataRx) rxPending <= 1'b0; // cleared by the read

      if (txWrite) txData <= bus.outPort;

      // send level drops once the other board answers
      if (txWrite) txSend <= 1'b1;
      else if (rxReady) txSend <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/gameDisplayRegs.sv */
////////////////////
// game display registers
// LEDs, digits, decimal points, out-of-bounds and placement info
////////////////////
`default_nettype none

module gameDisplayRegs (
  input  logic                              clk,
  input  logic                              reset,
  input  battleshipPicoPkg::picoBus_t       bus,
  output battleshipPicoPkg::displayRegs_t   display,
  output battleshipPicoPkg::placementInfo_t placement,
  output battleshipPicoPkg::byte_t          outOfBounds
);
  import battleshipPicoPkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      display     <= '0;
      placement   <= '0;
      outOfBounds <= '0;
    end else if (bus.writeStrobe) begin
      case (bus.portId)
        paLeds:          display.leds          <= bus.outPort;
        paDig0:          display.dig0          <= bus.outPort[4:0];
        paDig1:          display.dig1          <= bus.outPort[4:0];
        paDig2:          display.dig2          <= bus.outPort[4:0];
        paDig3:          display.dig3          <= bus.outPort[4:0];
        paDecimalPoints: display.decimalPoints <= bus.outPort[3:0]; // lower four only
        paOutOfBounds:   outOfBounds           <= bus.outPort;      // all ones = off board

        ////////////////////
        // ship placement state for the ghost-ship icon
        paPlaceDone:   placement.placementDone <= bus.outPort[1:0];
        paOrientation: placement.orientation   <= bus.outPort[3:0];
        paShipInfo:    placement.shipInfo      <= bus.outPort;

        default: ; // not ours
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/boardRamSteer.sv */
////////////////////
// board RAM steering
// routes cursor, addresses, enables and write values to the
// selected board RAM and returns its read cell
////////////////////
`default_nettype none

module boardRamSteer (
  input  logic                          clk,
  input  logic                          reset,
  input  battleshipPicoPkg::picoBus_t   bus,
  input  battleshipPicoPkg::cellValue_t usReadValue,
  input  battleshipPicoPkg::cellValue_t themReadValue,
  output battleshipPicoPkg::boardRam_t  usRamPort,
  output battleshipPicoPkg::boardRam_t  themRamPort,
  output battleshipPicoPkg::byte_t      cursor,
  output battleshipPicoPkg::cellValue_t ramReadData
);
  import battleshipPicoPkg::*;

  logic ramSelect; // 0 = us, 1 = them
  logic useUs;

  assign useUs = (ramSelect == usRam);

  always_ff @(posedge clk) begin
    if (reset) begin
      ramSelect   <= usRam;
      cursor      <= '0;
      usRamPort   <= '0;
      themRamPort <= '0;
    end else if (bus.writeStrobe) begin
      case (bus.portId)
        paRamSelect: ramSelect <= bus.outPort[0];

        ////////////////////
        // read request, also stops any write in progress
        paCursorCheck: begin
          usRamPort.writeEnable   <= 1'b0;
          themRamPort.writeEnable <= 1'b0;
          cursor                  <= bus.outPort; // display follows the read
          if (useUs) usRamPort.readAddr <= bus.outPort;
          else themRamPort.readAddr <= bus.outPort;
        end

        // write address arms the enable of the selected board
        paRamWriteAddr: begin
          if (useUs) begin
            usRamPort.writeAddr   <= bus.outPort;
            usRamPort.writeEnable <= 1'b1;
          end else begin
            themRamPort.writeAddr   <= bus.outPort;
            themRamPort.writeEnable <= 1'b1;
          end
        end

        paRamWriteValue: begin
          if (useUs) usRamPort.writeValue <= bus.outPort[1:0];
          else themRamPort.writeValue <= bus.outPort[1:0];
        end

        ////////////////////
        // extra ship cells, only our own board is probed
        paShipCheck1, paShipCheck2, paShipCheck3, paShipCheck4: begin
          usRamPort.writeEnable <= 1'b0;
          cursor                <= bus.outPort;
        end

        default: ;
      endcase
    end
  end

  assign ramReadData = (ramSelect == themRam) ? themReadValue : usReadValue;

endmodule

`default_nettype wire

/* logic/occupancyAccumulator.sv */
////////////////////
// occupancy accumulator
// sums cells read from the "us" board and flags a legal placement
////////////////////
`default_nettype none

module occupancyAccumulator (
  input  logic                          clk,
  input  logic                          reset,
  input  battleshipPicoPkg::picoBus_t   bus,
  input  battleshipPicoPkg::cellValue_t usReadValue,
  input  battleshipPicoPkg::byte_t      outOfBounds,
  output logic                          placementValid
);
  import battleshipPicoPkg::*;

  byte_t      cellSum;      // running sum of cells under the ship
  logic       clearPending; // valid flag was read, clear on the next cycle
  logic [8:0] sumWide;
  byte_t      sumNext;

  assign sumWide = {1'b0, cellSum} + {7'b0, usReadValue};
  assign sumNext = sumWide[8] ? 8'hFF : sumWide[7:0]; // stick at full scale

  always_ff @(posedge clk) begin
    if (reset) begin
      cellSum      <= '0;
      clearPending <= 1'b0;
    end else if (bus.portId == paValidFlag) begin
      clearPending <= 1'b1; // hold sum while the flag is being read
    end else if (clearPending) begin
      cellSum      <= '0;
      clearPending <= 1'b0;
    end else begin
      cellSum <= sumNext;
    end
  end

  // any occupied cell or an off-board cursor blocks placement
  assign placementValid = (outOfBounds != outOfBoundsMark) && (cellSum == '0);

endmodule

`default_nettype wire

/* logic/battleshipPicoPkg.sv */
////////////////////
// battleship pico package
// port map, flag values and the bus/board structs shared by the
// processor-side port blocks
////////////////////
`default_nettype none

package battleshipPicoPkg;

  typedef logic [7:0] portAddr_t;  // processor port id
  typedef logic [7:0] byte_t;      // processor data word
  typedef logic [1:0] cellValue_t; // empty, ship, hit or miss

  ////////////////////
  // write ports
  localparam portAddr_t paLeds          = 8'h02;
  localparam portAddr_t paDig3          = 8'h03;
  localparam portAddr_t paDig2          = 8'h04;
  localparam portAddr_t paDig1          = 8'h05;
  localparam portAddr_t paDig0          = 8'h06;
  localparam portAddr_t paDecimalPoints = 8'h07;
  localparam portAddr_t paOutOfBounds   = 8'h08;
  localparam portAddr_t paCursorCheck   = 8'h0A; // also the first ship check
  localparam portAddr_t paRamWriteAddr  = 8'h0B;
  localparam portAddr_t paPlaceDone     = 8'h0D;
  localparam portAddr_t paOrientation   = 8'h0E;
  localparam portAddr_t paShipInfo      = 8'h0F;
  localparam portAddr_t paRamSelect     = 8'h13;
  localparam portAddr_t paRamWriteValue = 8'h18;
  localparam portAddr_t paShipCheck1    = 8'h1A;
  localparam portAddr_t paShipCheck2    = 8'h1B;
  localparam portAddr_t paShipCheck3    = 8'h1C;
  localparam portAddr_t paShipCheck4    = 8'h1D;
  localparam portAddr_t paDataTx        = 8'h1E;

  ////////////////////
  // read ports
  localparam portAddr_t paButtons    = 8'h00;
  localparam portAddr_t paSwitches   = 8'h01;
  localparam portAddr_t paLinkStatus = 8'h09; // {conn, rx pending, 6'b0}
  localparam portAddr_t paValidFlag  = 8'h0C;
  localparam portAddr_t paDataRx     = 8'h19;
  localparam portAddr_t paDataRam    = 8'h1F;

  localparam byte_t outOfBoundsMark = 8'hFF; // cursor off the board
  localparam byte_t validFlag       = 8'h01;
  localparam byte_t invalidFlag     = 8'h00;
  localparam logic  usRam           = 1'b0;  // our ships
  localparam logic  themRam         = 1'b1;  // our guesses at theirs

  typedef struct packed {
    portAddr_t portId;
    byte_t     outPort;
    logic      writeStrobe;
  } picoBus_t;

  typedef struct packed {
    byte_t      readAddr;
    byte_t      writeAddr;
    logic       writeEnable;
    cellValue_t writeValue;
  } boardRam_t;

  typedef struct packed {
    byte_t      leds;
    logic [4:0] dig0;
    logic [4:0] dig1;
    logic [4:0] dig2;
    logic [4:0] dig3;
    logic [3:0] decimalPoints;
  } displayRegs_t;

  typedef struct packed {
    logic [1:0] placementDone; // done bit plus whose turn
    logic [3:0] orientation;
    byte_t      shipInfo;      // ships left and current length
  } placementInfo_t;

endpackage

`default_nettype wire
